// File: design/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// --------------------
// widths
// --------------------
`define WB_XLEN        32
`define WB_RF_AW       5
`define WB_CSR_NUM_W   14
`define WB_ECODE_W     6
`define WB_ESUB_W      9

// --------------------
// csr numbers
// --------------------
`define WB_CSR_CRMD    14'h0
`define WB_CSR_PRMD    14'h1
`define WB_CSR_ESTAT   14'h5
`define WB_CSR_ERA     14'h6
`define WB_CSR_EENTRY  14'hc

`define WB_ECODE_SYS   6'hb       // syscall

// reset values and writable field masks
`define WB_CRMD_RST    32'h0000_0008  // da=1, plv=0, ie=0
`define WB_CRMD_WMASK  32'h0000_0007  // plv, ie
`define WB_PRMD_WMASK  32'h0000_0007  // pplv, pie
`define WB_ESTAT_WMASK 32'h0000_0003  // is[1:0] only
`define WB_ERA_WMASK   32'hffff_ffff
`define WB_EENTRY_WMASK 32'hffff_ffc0 // entry is 64-byte aligned

`endif

// File: design/wb_pkg.sv
`include "wb_consts.svh"

package wb_pkg;

    // --------------------
    // mode register
    // --------------------
    typedef union packed {
        logic [`WB_XLEN-1:0] raw;
        struct packed {
            logic [27:0] rsvd;
            logic        da;       // direct address translation
            logic        ie;       // global interrupt enable
            logic [1:0]  plv;      // current privilege
        } f;
    } crmd_u;

    typedef union packed {
        logic [`WB_XLEN-1:0] raw;
        struct packed {
            logic [28:0] rsvd;
            logic        pie;
            logic [1:0]  pplv;
        } f;
    } prmd_u;

    typedef union packed {
        logic [`WB_XLEN-1:0] raw;
        struct packed {
            logic                  rsvd_hi;
            logic [`WB_ESUB_W-1:0] esubcode;
            logic [`WB_ECODE_W-1:0] ecode;
            logic [2:0]            rsvd_lo;
            logic [12:0]           is;       // interrupt status, bits 1:0 are soft
        } f;
    } estat_u;

endpackage

// File: design/wb_csr_if.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

interface wb_csr_if;

    logic                   ex;        // exception raised at writeback
    logic [`WB_ECODE_W-1:0] ecode;
    logic [`WB_ESUB_W-1:0]  esubcode;
    logic [`WB_XLEN-1:0]    pc;        // pc of the excepting instruction
    logic                   ertn;      // exception return
    logic [1:0]             plv;       // current privilege from the csr unit

    modport stage (
        output ex,
        output ecode,
        output esubcode,
        output pc,
        output ertn,
        input  plv
    );

    modport csr (
        input  ex,
        input  ecode,
        input  esubcode,
        input  pc,
        input  ertn,
        output plv
    );

endinterface

// File: design/wb_stage.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

module wb_stage (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  mem_valid,
    input  logic [`WB_XLEN-1:0]   mem_pc,
    input  logic [`WB_RF_AW-1:0]  mem_dest,
    input  logic [`WB_XLEN-1:0]   mem_result,
    input  logic                  mem_gr_we,
    input  logic                  mem_ex_sys,
    input  logic                  mem_is_ertn,
    output logic                  wb_allow_in,

    output logic                  rf_we,
    output logic [`WB_RF_AW-1:0]  rf_waddr,
    output logic [`WB_XLEN-1:0]   rf_wdata,

    output logic [`WB_RF_AW-1:0]  fwd_dest,
    output logic [`WB_XLEN-1:0]   fwd_data,

    output logic [`WB_XLEN-1:0]   debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [`WB_RF_AW-1:0]  debug_wb_rf_wnum,
    output logic [`WB_XLEN-1:0]   debug_wb_rf_wdata,

    wb_csr_if.stage               csr
);

    logic                 wb_valid;
    logic                 ready_go;

    logic [`WB_XLEN-1:0]  pc_q;
    logic [`WB_RF_AW-1:0] dest_q;
    logic [`WB_XLEN-1:0]  result_q;
    logic                 gr_we_q;
    logic                 ex_sys_q;
    logic                 is_ertn_q;

    assign ready_go    = 1'b1;                 // writeback never stalls
    assign wb_allow_in = ~wb_valid | ready_go;

    // --------------------
    // stage register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n || csr.ex) begin
            wb_valid <= 1'b0;                  // exception kills the slot
        end else if (wb_allow_in) begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allow_in) begin
            pc_q      <= mem_pc;
            dest_q    <= mem_dest;
            result_q  <= mem_result;
            gr_we_q   <= mem_gr_we;
            ex_sys_q  <= mem_ex_sys;
            is_ertn_q <= mem_is_ertn;
        end
    end

    assign rf_we    = wb_valid & gr_we_q & ~ex_sys_q;   // no write on syscall
    assign rf_waddr = dest_q;
    assign rf_wdata = result_q;

    assign fwd_dest = dest_q & {`WB_RF_AW{wb_valid}};
    assign fwd_data = result_q;

    // exception events toward the csr unit
    assign csr.ex       = wb_valid & ex_sys_q;
    assign csr.ecode    = ex_sys_q ? `WB_ECODE_SYS : '0;
    assign csr.esubcode = '0;
    assign csr.pc       = pc_q;
    assign csr.ertn     = wb_valid & is_ertn_q & (csr.plv == 2'd0);  // ertn only from plv0

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = result_q;

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

module regfile (
    input  logic                 clk,

    input  logic                 we,
    input  logic [`WB_RF_AW-1:0] waddr,
    input  logic [`WB_XLEN-1:0]  wdata,

    input  logic [`WB_RF_AW-1:0] raddr1,
    output logic [`WB_XLEN-1:0]  rdata1,
    input  logic [`WB_RF_AW-1:0] raddr2,
    output logic [`WB_XLEN-1:0]  rdata2
);

    localparam int DEPTH = 1 << `WB_RF_AW;

    logic [`WB_XLEN-1:0] rf_mem [DEPTH];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            rf_mem[waddr] <= wdata;            // r0 is never written
        end
    end

    // --------------------
    // read ports
    // --------------------
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = rf_mem[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = rf_mem[raddr2];
        end
    end

endmodule

// File: design/csr_unit.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

module csr_unit
    import wb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    wb_csr_if.csr                    wb,

    input  logic [`WB_CSR_NUM_W-1:0] csr_num,
    input  logic                     csr_we,
    input  logic [`WB_XLEN-1:0]      csr_wmask,
    input  logic [`WB_XLEN-1:0]      csr_wdata,
    output logic [`WB_XLEN-1:0]      csr_rdata,

    output logic                     flush,
    output logic [`WB_XLEN-1:0]      flush_target
);

    crmd_u               crmd_q;
    prmd_u               prmd_q;
    estat_u              estat_q;
    logic [`WB_XLEN-1:0] era_q;
    logic [`WB_XLEN-1:0] eentry_q;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    // masked write restricted to the writable fields
    function automatic logic [`WB_XLEN-1:0] csr_merge(
        input logic [`WB_XLEN-1:0] old_val,
        input logic [`WB_XLEN-1:0] field_mask
    );
        logic [`WB_XLEN-1:0] m;
        m = csr_wmask & field_mask;
        return (old_val & ~m) | (csr_wdata & m);
    endfunction

    assign wr_crmd   = csr_we & (csr_num == `WB_CSR_CRMD);
    assign wr_prmd   = csr_we & (csr_num == `WB_CSR_PRMD);
    assign wr_estat  = csr_we & (csr_num == `WB_CSR_ESTAT);
    assign wr_era    = csr_we & (csr_num == `WB_CSR_ERA);
    assign wr_eentry = csr_we & (csr_num == `WB_CSR_EENTRY);

    // --------------------
    // mode and previous mode
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q.raw <= `WB_CRMD_RST;
        end else if (wb.ex) begin
            crmd_q.f.plv <= 2'd0;              // trap into kernel
            crmd_q.f.ie  <= 1'b0;
        end else if (wb.ertn) begin
            crmd_q.f.plv <= prmd_q.f.pplv;
            crmd_q.f.ie  <= prmd_q.f.pie;
        end else if (wr_crmd) begin
            crmd_q.raw <= csr_merge(crmd_q.raw, `WB_CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prmd_q.raw <= '0;
        end else if (wb.ex) begin
            prmd_q.f.pplv <= crmd_q.f.plv;
            prmd_q.f.pie  <= crmd_q.f.ie;
        end else if (wr_prmd) begin
            prmd_q.raw <= csr_merge(prmd_q.raw, `WB_PRMD_WMASK);
        end
    end

    // --------------------
    // status and addresses
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            estat_q.raw <= '0;
        end else if (wb.ex) begin
            estat_q.f.ecode    <= wb.ecode;
            estat_q.f.esubcode <= wb.esubcode;
        end else if (wr_estat) begin
            estat_q.raw <= csr_merge(estat_q.raw, `WB_ESTAT_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            era_q <= '0;
        end else if (wb.ex) begin
            era_q <= wb.pc;
        end else if (wr_era) begin
            era_q <= csr_merge(era_q, `WB_ERA_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eentry_q <= '0;
        end else if (wr_eentry) begin
            eentry_q <= csr_merge(eentry_q, `WB_EENTRY_WMASK);
        end
    end

    always_comb begin
        case (csr_num)
            `WB_CSR_CRMD:   csr_rdata = crmd_q.raw;
            `WB_CSR_PRMD:   csr_rdata = prmd_q.raw;
            `WB_CSR_ESTAT:  csr_rdata = estat_q.raw;
            `WB_CSR_ERA:    csr_rdata = era_q;
            `WB_CSR_EENTRY: csr_rdata = eentry_q;
            default:        csr_rdata = '0;
        endcase
    end

    assign wb.plv       = crmd_q.f.plv;
    assign flush        = wb.ex | wb.ertn;
    assign flush_target = wb.ex ? eentry_q : era_q;   // ex wins over ertn

endmodule

// File: design/wb_subsys_top.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

module wb_subsys_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // memory stage bundle
    input  logic                     mem_valid,
    input  logic [`WB_XLEN-1:0]      mem_pc,
    input  logic [`WB_RF_AW-1:0]     mem_dest,
    input  logic [`WB_XLEN-1:0]      mem_result,
    input  logic                     mem_gr_we,
    input  logic                     mem_ex_sys,
    input  logic                     mem_is_ertn,
    output logic                     wb_allow_in,

    output logic [`WB_RF_AW-1:0]     fwd_dest,
    output logic [`WB_XLEN-1:0]      fwd_data,

    output logic [`WB_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output logic [`WB_RF_AW-1:0]     debug_wb_rf_wnum,
    output logic [`WB_XLEN-1:0]      debug_wb_rf_wdata,

    // register file read ports
    input  logic [`WB_RF_AW-1:0]     raddr1,
    output logic [`WB_XLEN-1:0]      rdata1,
    input  logic [`WB_RF_AW-1:0]     raddr2,
    output logic [`WB_XLEN-1:0]      rdata2,

    // --------------------
    // csr access and redirect
    // --------------------
    input  logic [`WB_CSR_NUM_W-1:0] csr_num,
    input  logic                     csr_we,
    input  logic [`WB_XLEN-1:0]      csr_wmask,
    input  logic [`WB_XLEN-1:0]      csr_wdata,
    output logic [`WB_XLEN-1:0]      csr_rdata,
    output logic                     flush,
    output logic [`WB_XLEN-1:0]      flush_target
);

    logic                 rf_we;
    logic [`WB_RF_AW-1:0] rf_waddr;
    logic [`WB_XLEN-1:0]  rf_wdata;

    wb_csr_if csr_if0 ();

    wb_stage wb_stage0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_dest          (mem_dest),
        .mem_result        (mem_result),
        .mem_gr_we         (mem_gr_we),
        .mem_ex_sys        (mem_ex_sys),
        .mem_is_ertn       (mem_is_ertn),
        .wb_allow_in       (wb_allow_in),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .fwd_dest          (fwd_dest),
        .fwd_data          (fwd_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .csr               (csr_if0.stage)
    );

    regfile regfile0 (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2)
    );

    csr_unit csr_unit0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb           (csr_if0.csr),
        .csr_num      (csr_num),
        .csr_we       (csr_we),
        .csr_wmask    (csr_wmask),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .flush        (flush),
        .flush_target (flush_target)
    );

endmodule

// File: dv/tb_wb_subsys.sv
`timescale 1ns/100ps
`include "wb_consts.svh"

module tb_wb_subsys;

    logic                     clk;
    logic                     rst_n;
    logic                     mem_valid;
    logic [`WB_XLEN-1:0]      mem_pc;
    logic [`WB_RF_AW-1:0]     mem_dest;
    logic [`WB_XLEN-1:0]      mem_result;
    logic                     mem_gr_we;
    logic                     mem_ex_sys;
    logic                     mem_is_ertn;
    logic                     wb_allow_in;
    logic [`WB_RF_AW-1:0]     fwd_dest;
    logic [`WB_XLEN-1:0]      fwd_data;
    logic [`WB_XLEN-1:0]      debug_wb_pc;
    logic [3:0]               debug_wb_rf_we;
    logic [`WB_RF_AW-1:0]     debug_wb_rf_wnum;
    logic [`WB_XLEN-1:0]      debug_wb_rf_wdata;
    logic [`WB_RF_AW-1:0]     raddr1;
    logic [`WB_XLEN-1:0]      rdata1;
    logic [`WB_RF_AW-1:0]     raddr2;
    logic [`WB_XLEN-1:0]      rdata2;
    logic [`WB_CSR_NUM_W-1:0] csr_num;
    logic                     csr_we;
    logic [`WB_XLEN-1:0]      csr_wmask;
    logic [`WB_XLEN-1:0]      csr_wdata;
    logic [`WB_XLEN-1:0]      csr_rdata;
    logic                     flush;
    logic [`WB_XLEN-1:0]      flush_target;

    logic [31:0] csr_m [16];    // expected csr contents by csr number
    logic [31:0] csr_wr [16];   // writable bits per csr
    logic [31:0] rf_m [32];
    logic [4:0]  keep_dest;

    wb_subsys_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // checking and waiting
    // --------------------
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s never came", what);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic wait_allow_in();
        int n = 0;
        @(negedge clk);
        while (!wb_allow_in) begin
            n++;
            if (n > 20) abort_on_timeout("wb_allow_in");
            @(negedge clk);
        end
    endtask

    task automatic wait_flush();
        int n = 0;
        @(negedge clk);
        while (!flush) begin
            n++;
            if (n > 20) abort_on_timeout("flush");
            @(negedge clk);
        end
    endtask

    // --------------------
    // bus drivers
    // --------------------
    task automatic drive_bundle(input logic [31:0] pc, input logic [4:0] dest,
                                input logic [31:0] res, input logic gr_we,
                                input logic ex_sys, input logic ertn);
        mem_valid   <= 1'b1;
        mem_pc      <= pc;
        mem_dest    <= dest;
        mem_result  <= res;
        mem_gr_we   <= gr_we;
        mem_ex_sys  <= ex_sys;
        mem_is_ertn <= ertn;
    endtask

    // returns just after the accept edge
    task automatic send_bundle(input logic [31:0] pc, input logic [4:0] dest,
                               input logic [31:0] res, input logic gr_we,
                               input logic ex_sys, input logic ertn);
        wait_allow_in();
        @(posedge clk);
        drive_bundle(pc, dest, res, gr_we, ex_sys, ertn);
        @(posedge clk);
        mem_valid <= 1'b0;
    endtask

    task automatic check_retire(input string name, input logic [31:0] pc,
                                input logic [4:0] dest, input logic [31:0] res,
                                input logic we);
        check_eq({name, ": fwd_dest"}, dest, fwd_dest);
        check_eq({name, ": fwd_data"}, res, fwd_data);
        check_eq({name, ": debug pc"}, pc, debug_wb_pc);
        check_eq({name, ": debug we"}, {4{we}}, debug_wb_rf_we);
        check_eq({name, ": debug wnum"}, dest, debug_wb_rf_wnum);
        check_eq({name, ": debug wdata"}, res, debug_wb_rf_wdata);
    endtask

    task automatic check_reg(input string name, input logic [4:0] addr, input logic [31:0] exp);
        @(posedge clk);
        raddr1 <= addr;
        raddr2 <= addr;
        @(negedge clk);
        check_eq({name, ": rdata1"}, exp, rdata1);
        check_eq({name, ": rdata2"}, exp, rdata2);
    endtask

    task automatic csr_write(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] data);
        logic [31:0] m;
        m = mask & csr_wr[num];                 // only writable bits follow the data
        csr_m[num] = (csr_m[num] & ~m) | (data & m);
        @(posedge clk);
        csr_num   <= num;
        csr_we    <= 1'b1;
        csr_wmask <= mask;
        csr_wdata <= data;
        @(posedge clk);
        csr_we    <= 1'b0;
    endtask

    task automatic csr_read(input logic [13:0] num, output logic [31:0] data);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic check_all_csrs(input string name);
        logic [31:0] d;
        csr_read(`WB_CSR_CRMD, d);
        check_eq({name, ": crmd"}, csr_m[`WB_CSR_CRMD], d);
        csr_read(`WB_CSR_PRMD, d);
        check_eq({name, ": prmd"}, csr_m[`WB_CSR_PRMD], d);
        csr_read(`WB_CSR_ESTAT, d);
        check_eq({name, ": estat"}, csr_m[`WB_CSR_ESTAT], d);
        csr_read(`WB_CSR_ERA, d);
        check_eq({name, ": era"}, csr_m[`WB_CSR_ERA], d);
        csr_read(`WB_CSR_EENTRY, d);
        check_eq({name, ": eentry"}, csr_m[`WB_CSR_EENTRY], d);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic reset_test();
        check_all_csrs("reset");
        @(negedge clk);
        check_eq("reset: flush", 0, flush);
        check_eq("reset: allow_in", 1, wb_allow_in);
        check_eq("reset: debug we", 0, debug_wb_rf_we);
        check_eq("reset: fwd_dest", 0, fwd_dest);
    endtask

    task automatic write_read_test();
        logic [31:0] res;
        logic [31:0] res0;
        keep_dest = 5'($urandom % 31) + 5'd1;
        res = $urandom | 32'h1;
        res0 = $urandom | 32'h1;
        send_bundle(32'h1c00_0000, keep_dest, res, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        check_retire("write_read", 32'h1c00_0000, keep_dest, res, 1'b1);
        rf_m[keep_dest] = res;
        check_reg("write_read", keep_dest, res);
        check_eq("write_read: fwd_dest empty", 0, fwd_dest);   // stage drained
        send_bundle(32'h1c00_0004, 5'd0, res0, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        check_retire("write_r0", 32'h1c00_0004, 5'd0, res0, 1'b1);
        check_reg("write_r0", 5'd0, 32'h0);
    endtask

    task automatic no_write_test();
        logic [31:0] pcs [4];
        logic [4:0]  dests [4];
        logic [31:0] ress [4];
        logic [4:0]  base;
        send_bundle(32'h1c00_0100, keep_dest, ~rf_m[keep_dest], 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        check_eq("no_write: debug we", 0, debug_wb_rf_we);
        check_reg("no_write", keep_dest, rf_m[keep_dest]);
        base = 5'($urandom % 31);
        for (int i = 0; i < 4; i++) begin
            pcs[i]   = 32'h1c00_0200 + 32'(i * 4);
            dests[i] = 5'((32'(base) + 32'(i)) % 31 + 1);   // distinct, never r0
            ress[i]  = $urandom;
        end
        wait_allow_in();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            drive_bundle(pcs[i], dests[i], ress[i], 1'b1, 1'b0, 1'b0);
            if (i > 0) begin
                @(negedge clk);
                check_retire("back_to_back", pcs[i-1], dests[i-1], ress[i-1], 1'b1);
                check_eq("back_to_back: allow_in", 1, wb_allow_in);
            end
        end
        @(posedge clk);
        mem_valid <= 1'b0;
        @(negedge clk);
        check_retire("back_to_back", pcs[3], dests[3], ress[3], 1'b1);
        for (int i = 0; i < 4; i++) begin
            rf_m[dests[i]] = ress[i];
            check_reg("back_to_back", dests[i], ress[i]);
        end
    endtask

    task automatic csr_mask_test();
        logic [31:0] d;
        csr_write(`WB_CSR_EENTRY, 32'hffff_ffff, $urandom);
        check_all_csrs("csr_mask eentry full");
        csr_write(`WB_CSR_EENTRY, 32'h0000_ffff, 32'hffff_ffff);   // low bits masked in
        csr_read(`WB_CSR_EENTRY, d);
        check_eq("csr_mask: eentry low bits", 0, {26'b0, d[5:0]});
        csr_write(`WB_CSR_ESTAT, 32'hffff_ffff, 32'hffff_ffff);
        csr_write(`WB_CSR_ESTAT, 32'h0000_0001, 32'h0);
        check_all_csrs("csr_mask estat");
        csr_write(`WB_CSR_CRMD, 32'hffff_fff8, 32'hffff_ffff);   // nothing writable here
        csr_write(`WB_CSR_PRMD, 32'hffff_ffff, $urandom);
        csr_write(`WB_CSR_ERA, 32'hffff_0000, $urandom);
        check_all_csrs("csr_mask others");
    endtask

    task automatic syscall_test();
        logic [31:0] pc;
        logic [31:0] old;
        logic [31:0] d;
        csr_write(`WB_CSR_CRMD, 32'h3, 32'h3);                   // privilege 3
        check_all_csrs("syscall setup");
        pc = 32'h1c00_1000 | ($urandom & 32'h0000_0ffc);
        old = rf_m[keep_dest];
        send_bundle(pc, keep_dest, ~old, 1'b1, 1'b1, 1'b0);
        wait_flush();
        check_eq("syscall: flush_target", csr_m[`WB_CSR_EENTRY], flush_target);
        check_eq("syscall: debug we", 0, debug_wb_rf_we);
        csr_m[`WB_CSR_PRMD][2:0]    = csr_m[`WB_CSR_CRMD][2:0];   // pie, pplv
        csr_m[`WB_CSR_CRMD][2:0]    = 3'b000;
        csr_m[`WB_CSR_ESTAT][21:16] = 6'hb;
        csr_m[`WB_CSR_ESTAT][30:22] = 9'h0;
        csr_m[`WB_CSR_ERA]          = pc;
        @(negedge clk);
        check_eq("syscall: flush after", 0, flush);
        check_all_csrs("syscall");
        csr_read(`WB_CSR_ERA, d);
        check_eq("syscall: era", pc, d);
        csr_read(`WB_CSR_ESTAT, d);
        check_eq("syscall: ecode", 32'hb, {26'b0, d[21:16]});
        csr_read(`WB_CSR_CRMD, d);
        check_eq("syscall: plv", 0, {30'b0, d[1:0]});
        csr_read(`WB_CSR_PRMD, d);
        check_eq("syscall: pplv", 3, {30'b0, d[1:0]});
        check_reg("syscall: dest kept", keep_dest, old);
    endtask

    task automatic ertn_test();
        logic [31:0] d;
        send_bundle(32'h1c00_2000, 5'd0, 32'h0, 1'b0, 1'b0, 1'b1);
        wait_flush();
        check_eq("ertn_plv0: flush_target", csr_m[`WB_CSR_ERA], flush_target);
        csr_m[`WB_CSR_CRMD][2:0] = csr_m[`WB_CSR_PRMD][2:0];
        check_all_csrs("ertn_plv0");
        csr_read(`WB_CSR_CRMD, d);
        check_eq("ertn_plv0: plv", 3, {30'b0, d[1:0]});
        send_bundle(32'h1c00_2004, 5'd0, 32'h0, 1'b0, 1'b0, 1'b1);
        @(negedge clk);
        check_eq("ertn_plv3: flush", 0, flush);       // ertn ignored outside plv0
        check_all_csrs("ertn_plv3");
    endtask

    initial begin
        void'($urandom(39583));
        rst_n       = 1'b0;
        mem_valid   = 1'b0;
        mem_pc      = '0;
        mem_dest    = '0;
        mem_result  = '0;
        mem_gr_we   = 1'b0;
        mem_ex_sys  = 1'b0;
        mem_is_ertn = 1'b0;
        raddr1      = '0;
        raddr2      = '0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wdata   = '0;
        foreach (csr_m[i]) begin
            csr_m[i]  = 32'h0;
            csr_wr[i] = 32'h0;
        end
        csr_m[`WB_CSR_CRMD]    = 32'h0000_0008;
        csr_wr[`WB_CSR_CRMD]   = 32'h0000_0007;
        csr_wr[`WB_CSR_PRMD]   = 32'h0000_0007;
        csr_wr[`WB_CSR_ESTAT]  = 32'h0000_0003;
        csr_wr[`WB_CSR_ERA]    = 32'hffff_ffff;
        csr_wr[`WB_CSR_EENTRY] = 32'hffff_ffc0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_test();
        write_read_test();
        no_write_test();
        csr_mask_test();
        syscall_test();
        ertn_test();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/wb_pkg.sv
design/wb_csr_if.sv
design/wb_stage.sv
design/regfile.sv
design/csr_unit.sv
design/wb_subsys_top.sv
dv/tb_wb_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the writeback subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_wb_subsys \
        -o tb_wb_subsys; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_wb_subsys 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
